/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_execute_ctl
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/exe_ctl_params.svh */
`ifndef EXE_CTL_PARAMS_SVH
`define EXE_CTL_PARAMS_SVH

// Datapath and instruction width
`define XLEN 32

// ALU select width
`define ALU_SEL_W 4

// APB register port
`define APB_ADDR_W 4

// Saturating illegal-instruction counter
`define ILL_COUNT_W 16

// Register byte offsets
`define REG_CTRL      4'h0
`define REG_STATUS    4'h4
`define REG_ILL_COUNT 4'h8
`define REG_ILL_INSTR 4'hC

`endif

/* design/exe_ctl_pkg.sv */
`include "exe_ctl_params.svh"

package exe_ctl_pkg;

    // Encodings follow the existing ALU
    typedef enum logic [`ALU_SEL_W-1:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_XOR    = 4'b0010,
        ALU_ADD    = 4'b0011,
        ALU_SUB    = 4'b0100,
        ALU_PASS_B = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1010,
        ALU_SLTU   = 4'b1011,
        ALU_SLT    = 4'b1100
    } alu_op_e;

    // Execute-stage control word
    typedef struct packed {
        logic    a_sel;
        logic    b_sel;
        logic    pc_sel;
        logic    sign;
        logic    br_un;
        alu_op_e alu_sel;
    } exe_ctl_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`XLEN-1:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] prdata;
        logic             pready;
        logic             pslverr;
    } apb_rsp_t;

    // Register map
    typedef enum logic [`APB_ADDR_W-1:0] {
        ADDR_CTRL      = `REG_CTRL,
        ADDR_STATUS    = `REG_STATUS,
        ADDR_ILL_COUNT = `REG_ILL_COUNT,
        ADDR_ILL_INSTR = `REG_ILL_INSTR
    } reg_addr_e;

    // Reset value and pipeline bubble
    localparam exe_ctl_t CTL_BUBBLE = '{
        a_sel:   1'b0,
        b_sel:   1'b1,
        pc_sel:  1'b0,
        sign:    1'b0,
        br_un:   1'b0,
        alu_sel: ALU_PASS_B
    };

endpackage

/* design/exe_ctl_regs.sv */
`timescale 1ns/1ps

`include "exe_ctl_params.svh"

module exe_ctl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  exe_ctl_pkg::apb_req_t apb_req,
    input  logic                  ill_event,
    input  rv_isa_pkg::instr_u    ill_word,
    output exe_ctl_pkg::apb_rsp_t apb_rsp,
    output logic                  halted
);
    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    logic                    halt_on_ill;
    logic [`ILL_COUNT_W-1:0] ill_count;
    instr_u                  ill_instr;
    logic                    access;
    logic                    wr_en;
    logic                    wr_ctrl;
    logic                    wr_status;
    logic                    wr_count;
    logic                    addr_hit;
    logic [`XLEN-1:0]        rd_data;

    // Transfer completes in the access phase, no wait states
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    assign wr_ctrl   = wr_en && (apb_req.paddr == ADDR_CTRL);
    assign wr_status = wr_en && (apb_req.paddr == ADDR_STATUS);
    assign wr_count  = wr_en && (apb_req.paddr == ADDR_ILL_COUNT);

    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (apb_req.paddr)
            ADDR_CTRL:      rd_data[0] = halt_on_ill;
            ADDR_STATUS:    rd_data[0] = halted;
            ADDR_ILL_COUNT: rd_data[`ILL_COUNT_W-1:0] = ill_count;
            ADDR_ILL_INSTR: rd_data = ill_instr;
            default:        addr_hit = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~addr_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halt_on_ill <= 1'b0;
            halted      <= 1'b0;
            ill_count   <= '0;
            ill_instr   <= '0;
        end else begin
            if (wr_ctrl) begin
                halt_on_ill <= apb_req.pwdata[0];
            end

            // Set wins over the write-one-to-clear
            if (ill_event && halt_on_ill) begin
                halted <= 1'b1;
            end else if (wr_status && apb_req.pwdata[0]) begin
                halted <= 1'b0;
            end

            if (wr_count) begin
                ill_count <= ill_event ? `ILL_COUNT_W'(1) : '0;
            end else if (ill_event && (ill_count != '1)) begin
                ill_count <= ill_count + 1'b1;
            end

            if (ill_event) begin
                ill_instr <= ill_word;
            end
        end
    end

endmodule

/* design/exe_decoder.sv */
`timescale 1ns/1ps

module exe_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  rv_isa_pkg::instr_u    instruction,
    input  logic                  br_eq,
    input  logic                  br_lt,
    input  logic                  halted,
    output exe_ctl_pkg::exe_ctl_t ctl,
    output rv_isa_pkg::instr_u    instr_exe,
    output logic                  exe_valid,
    output logic                  ill_event,
    output rv_isa_pkg::instr_u    ill_word
);
    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    exe_ctl_t dec_ctl;
    logic     dec_legal;
    logic     f7_base;
    logic     f7_alt;
    logic     imm_alt;
    logic     issue;

    // Shared ALU mapping for OP and OP-IMM
    function automatic alu_op_e alu_for_funct3(logic [2:0] f3, logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign f7_base = (instruction.r_view.funct7 == F7_BASE);
    assign f7_alt  = (instruction.r_view.funct7 == F7_ALT);

    // In OP-IMM the upper bits only matter for right shifts
    assign imm_alt = f7_alt && (instruction.i_view.funct3 == F3_SR);

    always_comb begin
        dec_ctl   = CTL_BUBBLE;
        dec_legal = 1'b1;
        case (instruction.r_view.opcode)
            OPC_LUI: begin
                dec_ctl.alu_sel = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec_ctl.a_sel   = 1'b1;
                dec_ctl.alu_sel = ALU_ADD;
            end
            OPC_JAL: begin
                dec_ctl.a_sel   = 1'b1;
                dec_ctl.alu_sel = ALU_ADD;
                dec_ctl.sign    = 1'b1;
                dec_ctl.pc_sel  = 1'b1;
            end
            OPC_JALR: begin
                dec_ctl.alu_sel = ALU_ADD;
                dec_ctl.sign    = 1'b1;
                dec_ctl.pc_sel  = 1'b1;
                dec_legal       = (instruction.i_view.funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                dec_ctl.b_sel   = 1'b0;
                dec_ctl.alu_sel = ALU_ADD;
                // Comparator flags resolve the branch here
                case (instruction.r_view.funct3)
                    F3_BEQ:  dec_ctl.pc_sel = br_eq;
                    F3_BNE:  dec_ctl.pc_sel = ~br_eq;
                    F3_BLT:  dec_ctl.pc_sel = br_lt;
                    F3_BGE:  dec_ctl.pc_sel = ~br_lt;
                    F3_BLTU: begin
                        dec_ctl.br_un  = 1'b1;
                        dec_ctl.pc_sel = br_lt;
                    end
                    F3_BGEU: begin
                        dec_ctl.br_un  = 1'b1;
                        dec_ctl.pc_sel = ~br_lt;
                    end
                    default: dec_legal = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                dec_ctl.alu_sel = ALU_ADD;
                dec_ctl.sign    = 1'b1;
                case (instruction.i_view.funct3)
                    F3_LB, F3_LH, F3_LW: ;
                    F3_LBU, F3_LHU:      dec_ctl.sign = 1'b0;
                    default:             dec_legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                dec_ctl.alu_sel = ALU_ADD;
                dec_ctl.sign    = 1'b1;
                case (instruction.r_view.funct3)
                    F3_SB, F3_SH, F3_SW: ;
                    default:             dec_legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec_ctl.alu_sel = alu_for_funct3(instruction.i_view.funct3, imm_alt);
                case (instruction.i_view.funct3)
                    F3_ADD, F3_XOR, F3_OR, F3_AND: dec_ctl.sign = 1'b1;
                    F3_SLL:  dec_legal = f7_base;
                    F3_SR:   dec_legal = f7_base | f7_alt;
                    default: ;
                endcase
            end
            OPC_OP: begin
                dec_ctl.b_sel   = 1'b0;
                dec_ctl.alu_sel = alu_for_funct3(instruction.r_view.funct3, f7_alt);
                // Only ADD/SUB and SRL/SRA take the alternate funct7
                case (instruction.r_view.funct3)
                    F3_ADD, F3_SR: dec_legal = f7_base | f7_alt;
                    default:       dec_legal = f7_base;
                endcase
            end
            // FENCE, SYSTEM and unused opcodes
            default: dec_legal = 1'b0;
        endcase
    end

    assign issue     = instr_valid & ~halted & dec_legal;
    assign ill_event = instr_valid & ~halted & ~dec_legal;
    assign ill_word  = instruction;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctl       <= CTL_BUBBLE;
            exe_valid <= 1'b0;
            instr_exe <= '0;
        end else begin
            exe_valid <= issue;
            ctl       <= issue ? dec_ctl : CTL_BUBBLE;
            if (instr_valid) begin
                instr_exe <= instruction;
            end
        end
    end

endmodule

/* design/execute_ctl.sv */
`timescale 1ns/1ps

module execute_ctl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  rv_isa_pkg::instr_u    instruction,
    input  logic                  br_eq,
    input  logic                  br_lt,
    output exe_ctl_pkg::exe_ctl_t ctl,
    output rv_isa_pkg::instr_u    instr_exe,
    output logic                  exe_valid,
    input  exe_ctl_pkg::apb_req_t apb_req,
    output exe_ctl_pkg::apb_rsp_t apb_rsp
);
    import rv_isa_pkg::*;

    logic   halted;
    logic   ill_event;
    instr_u ill_word;

    // Decode and branch resolution, one cycle of latency
    exe_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .halted      (halted),
        .ctl         (ctl),
        .instr_exe   (instr_exe),
        .exe_valid   (exe_valid),
        .ill_event   (ill_event),
        .ill_word    (ill_word)
    );

    // Illegal-instruction status over APB
    exe_ctl_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .ill_event (ill_event),
        .ill_word  (ill_word),
        .apb_rsp   (apb_rsp),
        .halted    (halted)
    );

endmodule

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes, bits 6:0
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // ALU group, shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_funct3_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } ld_funct3_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } st_funct3_e;

    // Alternate encoding selects SUB and SRA
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } funct7_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_u;

endpackage

/* verif/tb_execute_ctl_tasks.svh */
`ifndef TB_EXECUTE_CTL_TASKS_SVH
`define TB_EXECUTE_CTL_TASKS_SVH

function automatic instr_u encode_r(logic [6:0] f7, logic [2:0] f3, opcode_e opc);
    instr_u w;
    w.r_view.funct7 = f7;
    w.r_view.rs2    = 5'd7;
    w.r_view.rs1    = 5'd3;
    w.r_view.funct3 = f3;
    w.r_view.rd     = 5'd11;
    w.r_view.opcode = opc;
    return w;
endfunction

function automatic exe_ctl_t make_ctl(logic a, logic b, logic pc, logic sgn, logic un,
                                      alu_op_e alu);
    exe_ctl_t c;
    c.a_sel   = a;
    c.b_sel   = b;
    c.pc_sel  = pc;
    c.sign    = sgn;
    c.br_un   = un;
    c.alu_sel = alu;
    return c;
endfunction

task automatic check_ctl(exe_ctl_t got, exe_ctl_t exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s: ctl %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_word(instr_u got, instr_u exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s: word %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_reg(logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s: value %h, expected %h", $time, what, got, exp);
    end
endtask

// One instruction in, outputs sampled mid-cycle after the register edge
task automatic issue(instr_u w, logic eq, logic lt);
    @(posedge clk);
    instr_valid <= 1'b1;
    instruction <= w;
    br_eq       <= eq;
    br_lt       <= lt;
    @(posedge clk);
    instr_valid <= 1'b0;
    @(negedge clk);
endtask

task automatic apb_write(logic [`APB_ADDR_W-1:0] addr, logic [`XLEN-1:0] data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
endtask

task automatic apb_read(logic [`APB_ADDR_W-1:0] addr, output logic [`XLEN-1:0] data,
                        output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    // No wait states on this port
    check_reg(`XLEN'(apb_rsp.pready), 1, "APB pready");
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
endtask

task automatic expect_reg(logic [`APB_ADDR_W-1:0] addr, logic [`XLEN-1:0] exp, string what);
    logic [`XLEN-1:0] data;
    logic             err;
    apb_read(addr, data, err);
    check_reg(data, exp, what);
    check_reg(`XLEN'(err), '0, {what, " pslverr"});
endtask

`endif

/* verif/tb_execute_ctl.sv */
`timescale 1ns/1ps

`include "exe_ctl_params.svh"

module tb_execute_ctl;
    import rv_isa_pkg::*;
    import exe_ctl_pkg::*;

    localparam int RESET_CYCLES   = 16;
    // 61 issues of 2 cycles and 11 APB transfers of 3, with wide margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * (61 * 2 + 11 * 3);

    logic     clk;
    logic     rst;
    logic     instr_valid;
    instr_u   instruction;
    logic     br_eq;
    logic     br_lt;
    exe_ctl_t ctl;
    instr_u   instr_exe;
    logic     exe_valid;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int       errors;
    int       checks;

    execute_ctl uut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .ctl         (ctl),
        .instr_exe   (instr_exe),
        .exe_valid   (exe_valid),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp)
    );

    `include "tb_execute_ctl_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * 20);
        $display("Timeout: the test sequence did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic alu_op_e expected_alu(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    task automatic check_issue(instr_u w, exe_ctl_t exp, string what);
        check_ctl(ctl, exp, what);
        check_word(instr_exe, w, what);
        check_reg(`XLEN'(exe_valid), 1, {what, " exe_valid"});
    endtask

    task automatic test_reset();
        check_reg(`XLEN'(exe_valid), 0, "reset exe_valid");
        check_ctl(ctl, CTL_BUBBLE, "reset ctl");
        check_word(instr_exe, '0, "reset instr_exe");
        expect_reg(`REG_CTRL, 0, "reset CTRL");
        expect_reg(`REG_STATUS, 0, "reset STATUS");
        expect_reg(`REG_ILL_COUNT, 0, "reset ILL_COUNT");
        expect_reg(`REG_ILL_INSTR, 0, "reset ILL_INSTR");
    endtask

    task automatic test_alu_ops();
        instr_u w;
        logic   sgn;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                w = encode_r(alt ? F7_ALT : F7_BASE, 3'(f3), OPC_OP);
                issue(w, 1'b0, 1'b0);
                check_issue(w, make_ctl(0, 0, 0, 0, 0, expected_alu(3'(f3), alt[0])), "OP");
                if (alt == 1 && f3 != 5) continue;
                w = encode_r(alt ? F7_ALT : F7_BASE, 3'(f3), OPC_OP_IMM);
                sgn = (f3 == 0 || f3 == 4 || f3 == 6 || f3 == 7);
                issue(w, 1'b0, 1'b0);
                check_issue(w, make_ctl(0, 1, 0, sgn, 0, expected_alu(3'(f3), alt[0])),
                            "OP-IMM");
            end
        end
    endtask

    task automatic test_branches();
        logic [2:0] codes [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        instr_u     w;
        logic       eq;
        logic       lt;
        logic       taken;
        logic       un;
        foreach (codes[i]) begin
            for (int fl = 0; fl < 4; fl++) begin
                eq = fl[0];
                lt = fl[1];
                case (codes[i])
                    3'b000:  taken = eq;
                    3'b001:  taken = ~eq;
                    3'b100:  taken = lt;
                    3'b110:  taken = lt;
                    default: taken = ~lt;
                endcase
                un = codes[i][1];
                w = encode_r(7'h15, codes[i], OPC_BRANCH);
                issue(w, eq, lt);
                check_issue(w, make_ctl(0, 0, taken, 0, un, ALU_ADD), "branch");
            end
        end
    endtask

    task automatic test_other_classes();
        instr_u w;
        w = encode_r(7'h2a, 3'b101, OPC_LUI);
        issue(w, 1'b0, 1'b0);
        check_issue(w, make_ctl(0, 1, 0, 0, 0, ALU_PASS_B), "LUI");
        w = encode_r(7'h2a, 3'b011, OPC_AUIPC);
        issue(w, 1'b0, 1'b0);
        check_issue(w, make_ctl(1, 1, 0, 0, 0, ALU_ADD), "AUIPC");
        w = encode_r(7'h11, 3'b110, OPC_JAL);
        issue(w, 1'b0, 1'b0);
        check_issue(w, make_ctl(1, 1, 1, 1, 0, ALU_ADD), "JAL");
        w = encode_r(7'h11, 3'b000, OPC_JALR);
        issue(w, 1'b0, 1'b0);
        check_issue(w, make_ctl(0, 1, 1, 1, 0, ALU_ADD), "JALR");
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 == 3) continue;
            w = encode_r(7'h01, 3'(f3), OPC_LOAD);
            issue(w, 1'b0, 1'b0);
            check_issue(w, make_ctl(0, 1, 0, f3 < 4, 0, ALU_ADD), "load");
        end
        for (int f3 = 0; f3 < 3; f3++) begin
            w = encode_r(7'h01, 3'(f3), OPC_STORE);
            issue(w, 1'b0, 1'b0);
            check_issue(w, make_ctl(0, 1, 0, 1, 0, ALU_ADD), "store");
        end
    endtask

    function automatic logic known_opcode(logic [6:0] op);
        return op inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                          OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM};
    endfunction

    task automatic illegal_issue(instr_u w, string what);
        issue(w, 1'b0, 1'b0);
        check_reg(`XLEN'(exe_valid), 0, {what, " exe_valid"});
        check_ctl(ctl, CTL_BUBBLE, what);
    endtask

    task automatic test_illegal();
        logic [`XLEN-1:0] rnd;
        logic [`XLEN-1:0] data;
        logic             err;
        illegal_issue(instr_u'(32'h0000_000f), "FENCE");
        illegal_issue(instr_u'(32'h0000_0073), "ECALL");
        rnd = $urandom;
        while (known_opcode(rnd[6:0])) begin
            rnd = $urandom;
        end
        illegal_issue(instr_u'(rnd), "unused opcode");
        expect_reg(`REG_ILL_COUNT, 3, "ILL_COUNT");
        expect_reg(`REG_ILL_INSTR, rnd, "ILL_INSTR");
        apb_read(4'h2, data, err);
        check_reg(`XLEN'(err), 1, "unmapped pslverr");
    endtask

    task automatic test_halt();
        instr_u add_w;
        add_w = encode_r(F7_BASE, F3_ADD, OPC_OP);
        apb_write(`REG_CTRL, 1);
        illegal_issue(instr_u'(32'h0010_0073), "EBREAK");
        expect_reg(`REG_STATUS, 1, "STATUS halted");
        issue(add_w, 1'b0, 1'b0);
        check_reg(`XLEN'(exe_valid), 0, "halted exe_valid");
        check_ctl(ctl, CTL_BUBBLE, "halted ctl");
        apb_write(`REG_STATUS, 1);
        expect_reg(`REG_STATUS, 0, "STATUS cleared");
        issue(add_w, 1'b0, 1'b0);
        check_issue(add_w, make_ctl(0, 0, 0, 0, 0, ALU_ADD), "ADD after halt");
    endtask

    initial begin
        void'($urandom(32'h8d4f_fec6));
        errors      = 0;
        checks      = 0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instruction = '0;
        br_eq       = 1'b0;
        br_lt       = 1'b0;
        apb_req     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset();
        test_alu_ops();
        test_branches();
        test_other_classes();
        test_illegal();
        test_halt();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
+incdir+verif
design/rv_isa_pkg.sv
design/exe_ctl_pkg.sv
design/exe_decoder.sv
design/exe_ctl_regs.sv
design/execute_ctl.sv
verif/tb_execute_ctl.sv
